// ==== test/drone_core_cases.txt ====
# throttle_us yaw_us roll_us pitch_us roll_angle pitch_angle (receiver widths, degrees)
# then expected motor_1_us motor_2_us motor_3_us motor_4_us
1403 1500 1500 1500 0 0 1400 1400 1400 1400
1201 1500 1500 1500 0 0 1200 1200 1200 1200
1020 1500 2000 1500 0 0 1020 1020 1020 1020
1400 1500 1600 1500 0 0 1500 1300 1300 1500
1400 1500 1500 1440 0 0 1340 1340 1460 1460
1400 1580 1500 1500 0 0 1320 1480 1320 1480
1400 1500 1500 1500 10 0 1360 1440 1440 1360
1400 1500 1500 1500 0 -12 1448 1448 1352 1352
1600 1460 1520 1540 3 -4 1704 1608 1576 1512
2000 1500 2000 2000 0 0 2000 2000 1000 2000
2300 900 900 900 0 0 1500 1500 2000 1500
950 1500 1500 1500 0 0 1000 1000 1000 1000
1040 1500 1000 1500 0 0 1000 1540 1540 1000
1400 1500 1500 1500 -200 0 2000 1000 1000 2000

// ==== drone_core.f ====
src/flight_pkg.sv
src/timebase.sv
src/rc_channel.sv
src/angle_controller.sv
src/motor_mixer.sv
src/esc_pwm.sv
src/drone_core.sv
test/drone_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module drone_core_tb \
    -f drone_core.f -o drone_core_sim > build.log 2>&1 \
    && ./obj_dir/drone_core_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

// ==== test/drone_core_tb.sv ====
// Flight-control core testbench, receiver pulses and IMU samples in, ESC pulse widths checked
module drone_core_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int clk_half    = 20;
    localparam int drive_delay = 5;
    localparam int wait_limit  = 50000;
    localparam int pulse_limit = 5000;

    logic                                      sys_clk;
    logic                                      resetn;
    logic                                      throttle_pwm;
    logic                                      yaw_pwm;
    logic                                      roll_pwm;
    logic                                      pitch_pwm;
    logic                                      imu_valid;
    logic signed [flight_pkg::angle_width-1:0] roll_angle;
    logic signed [flight_pkg::angle_width-1:0] pitch_angle;
    logic                                      motor_1_pwm;
    logic                                      motor_2_pwm;
    logic                                      motor_3_pwm;
    logic                                      motor_4_pwm;

    int check_count   = 0;
    int error_count   = 0;
    int timeout_count = 0;

    // One clock per microsecond, so widths in cycles equal widths in us
    drone_core #(
        .clks_per_us(1)
    ) drone_core_i (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .throttle_pwm(throttle_pwm),
        .yaw_pwm     (yaw_pwm),
        .roll_pwm    (roll_pwm),
        .pitch_pwm   (pitch_pwm),
        .imu_valid   (imu_valid),
        .roll_angle  (roll_angle),
        .pitch_angle (pitch_angle),
        .motor_1_pwm (motor_1_pwm),
        .motor_2_pwm (motor_2_pwm),
        .motor_3_pwm (motor_3_pwm),
        .motor_4_pwm (motor_4_pwm)
    );

    // 40 ns period
    always #clk_half sys_clk = ~sys_clk;

    // All four receiver pulses start together, each ends at its own width
    task automatic send_rc_pulses(input int thr_us, input int yaw_us, input int roll_us,
                                  input int pitch_us);
        int longest;
        int cyc;
        longest = thr_us;
        if (yaw_us > longest) begin
            longest = yaw_us;
        end
        if (roll_us > longest) begin
            longest = roll_us;
        end
        if (pitch_us > longest) begin
            longest = pitch_us;
        end
        @(posedge sys_clk);
        #drive_delay;
        throttle_pwm = 1'b1;
        yaw_pwm      = 1'b1;
        roll_pwm     = 1'b1;
        pitch_pwm    = 1'b1;
        cyc = 0;
        while (cyc < longest && cyc < pulse_limit) begin
            @(posedge sys_clk);
            #drive_delay;
            cyc++;
            throttle_pwm = cyc < thr_us;
            yaw_pwm      = cyc < yaw_us;
            roll_pwm     = cyc < roll_us;
            pitch_pwm    = cyc < pitch_us;
        end
        if (cyc < longest) begin
            $display("Receiver pulse of %0d cycles runs past the %0d cycle limit",
                     longest, pulse_limit);
            timeout_count++;
        end
        throttle_pwm = 1'b0;
        yaw_pwm      = 1'b0;
        roll_pwm     = 1'b0;
        pitch_pwm    = 1'b0;
        // Two sync flops plus the scale register
        repeat (4) @(posedge sys_clk);
    endtask

    // One-cycle IMU strobe, angles stay on the ports afterwards
    task automatic strobe_imu(input int roll_deg, input int pitch_deg);
        @(posedge sys_clk);
        #drive_delay;
        roll_angle  = flight_pkg::angle_width'(roll_deg);
        pitch_angle = flight_pkg::angle_width'(pitch_deg);
        imu_valid   = 1'b1;
        @(posedge sys_clk);
        #drive_delay;
        imu_valid = 1'b0;
    endtask

    // Sampled at the falling clock edge, away from output updates
    task automatic wait_motor_rise();
        int   cyc;
        logic prev;
        logic found;
        @(negedge sys_clk);
        prev  = motor_1_pwm;
        found = 1'b0;
        cyc   = 0;
        while (!found && cyc < wait_limit) begin
            @(negedge sys_clk);
            cyc++;
            found = !prev && motor_1_pwm;
            prev  = motor_1_pwm;
        end
        if (!found) begin
            $display("Timeout at %0t: no rising edge on motor_1_pwm within %0d cycles",
                     $time, wait_limit);
            timeout_count++;
        end
    endtask

    task automatic check_width(input string name, input int expected, input int measured);
        check_count++;
        if (measured != expected) begin
            $display("FAIL time %0t %s expected %0d us measured %0d us",
                     $time, name, expected, measured);
            error_count++;
        end
    endtask

    // Skip one frame so the new rates are in place, then measure the next
    task automatic measure_frame(input int exp_1, input int exp_2, input int exp_3,
                                 input int exp_4);
        int w1;
        int w2;
        int w3;
        int w4;
        int cyc;
        wait_motor_rise();
        if (timeout_count == 0) begin
            wait_motor_rise();
        end
        if (timeout_count > 0) begin
            return;
        end
        w1 = motor_1_pwm ? 1 : 0;
        w2 = motor_2_pwm ? 1 : 0;
        w3 = motor_3_pwm ? 1 : 0;
        w4 = motor_4_pwm ? 1 : 0;
        cyc = 0;
        while ((motor_1_pwm || motor_2_pwm || motor_3_pwm || motor_4_pwm)
               && cyc < pulse_limit) begin
            @(negedge sys_clk);
            cyc++;
            w1 += motor_1_pwm ? 1 : 0;
            w2 += motor_2_pwm ? 1 : 0;
            w3 += motor_3_pwm ? 1 : 0;
            w4 += motor_4_pwm ? 1 : 0;
        end
        if (cyc >= pulse_limit) begin
            $display("Timeout at %0t: ESC outputs still high after %0d cycles",
                     $time, pulse_limit);
            timeout_count++;
        end
        check_width("motor_1_pwm", exp_1, w1);
        check_width("motor_2_pwm", exp_2, w2);
        check_width("motor_3_pwm", exp_3, w3);
        check_width("motor_4_pwm", exp_4, w4);
    endtask

    initial begin
        int    fd;
        int    n;
        int    case_count;
        string line;
        int    thr_us;
        int    yaw_us;
        int    roll_us;
        int    pitch_us;
        int    roll_deg;
        int    pitch_deg;
        int    exp_1;
        int    exp_2;
        int    exp_3;
        int    exp_4;
        sys_clk      = 1'b0;
        resetn       = 1'b0;
        throttle_pwm = 1'b0;
        yaw_pwm      = 1'b0;
        roll_pwm     = 1'b0;
        pitch_pwm    = 1'b0;
        imu_valid    = 1'b0;
        roll_angle   = '0;
        pitch_angle  = '0;
        case_count   = 0;
        repeat (8) @(posedge sys_clk);
        #drive_delay;
        resetn = 1'b1;

        // Idle 1000 us pulses before any IMU sample
        measure_frame(1000, 1000, 1000, 1000);

        fd = $fopen("test/drone_core_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file test/drone_core_cases.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && timeout_count == 0) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", thr_us, yaw_us,
                                roll_us, pitch_us, roll_deg, pitch_deg,
                                exp_1, exp_2, exp_3, exp_4);
                    if (n == 10) begin
                        case_count++;
                        $display("Case %0d: receiver %0d %0d %0d %0d us, angles %0d %0d",
                                 case_count, thr_us, yaw_us, roll_us, pitch_us,
                                 roll_deg, pitch_deg);
                        send_rc_pulses(thr_us, yaw_us, roll_us, pitch_us);
                        strobe_imu(roll_deg, pitch_deg);
                        measure_frame(exp_1, exp_2, exp_3, exp_4);
                    end
                end
            end
            $fclose(fd);
        end
        if (case_count == 0) begin
            $display("No cases were read from the cases file");
            error_count++;
        end

        $display("Cases %0d, checks %0d, errors %0d, timeouts %0d",
                 case_count, check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src/drone_core.sv ====
// Flight-control core top, receiver inputs through controller and mixer to ESC outputs
module drone_core #(
    parameter int clks_per_us = 1
) (
    input  logic                                      sys_clk,
    input  logic                                      resetn,
    input  logic                                      throttle_pwm,
    input  logic                                      yaw_pwm,
    input  logic                                      roll_pwm,
    input  logic                                      pitch_pwm,
    input  logic                                      imu_valid,
    input  logic signed [flight_pkg::angle_width-1:0] roll_angle,
    input  logic signed [flight_pkg::angle_width-1:0] pitch_angle,
    output logic                                      motor_1_pwm,
    output logic                                      motor_2_pwm,
    output logic                                      motor_3_pwm,
    output logic                                      motor_4_pwm
);

    // Common timing
    logic us_tick;
    logic frame_start;

    // Stick values from the receiver
    logic [flight_pkg::stick_width-1:0] throttle_val;
    logic [flight_pkg::stick_width-1:0] yaw_val;
    logic [flight_pkg::stick_width-1:0] roll_val;
    logic [flight_pkg::stick_width-1:0] pitch_val;

    // Controller commands
    logic        [flight_pkg::stick_width-1:0] throttle_cmd;
    logic signed [flight_pkg::rate_width-1:0]  yaw_rate;
    logic signed [flight_pkg::rate_width-1:0]  roll_rate;
    logic signed [flight_pkg::rate_width-1:0]  pitch_rate;
    logic                                      ctrl_done;

    // Mixer outputs
    logic [flight_pkg::stick_width-1:0] motor_1_rate;
    logic [flight_pkg::stick_width-1:0] motor_2_rate;
    logic [flight_pkg::stick_width-1:0] motor_3_rate;
    logic [flight_pkg::stick_width-1:0] motor_4_rate;

    timebase #(
        .clks_per_us(clks_per_us)
    ) timebase_i (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .us_tick    (us_tick),
        .frame_start(frame_start)
    );

    // One receiver channel per stick
    rc_channel throttle_rc_i (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                              .pwm_in(throttle_pwm), .stick_value(throttle_val));
    rc_channel yaw_rc_i      (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                              .pwm_in(yaw_pwm), .stick_value(yaw_val));
    rc_channel roll_rc_i     (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                              .pwm_in(roll_pwm), .stick_value(roll_val));
    rc_channel pitch_rc_i    (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                              .pwm_in(pitch_pwm), .stick_value(pitch_val));

    // Started by each IMU sample
    angle_controller angle_controller_i (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .imu_valid     (imu_valid),
        .throttle_stick(throttle_val),
        .yaw_stick     (yaw_val),
        .roll_stick    (roll_val),
        .pitch_stick   (pitch_val),
        .roll_angle    (roll_angle),
        .pitch_angle   (pitch_angle),
        .throttle_cmd  (throttle_cmd),
        .yaw_rate      (yaw_rate),
        .roll_rate     (roll_rate),
        .pitch_rate    (pitch_rate),
        .ctrl_done     (ctrl_done)
    );

    motor_mixer motor_mixer_i (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .ctrl_done   (ctrl_done),
        .throttle_cmd(throttle_cmd),
        .yaw_rate    (yaw_rate),
        .roll_rate   (roll_rate),
        .pitch_rate  (pitch_rate),
        .motor_1_rate(motor_1_rate),
        .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate),
        .motor_4_rate(motor_4_rate)
    );

    // ESC outputs, all framed by the same frame_start
    esc_pwm esc_1_i (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                     .frame_start(frame_start), .motor_rate(motor_1_rate), .pwm_out(motor_1_pwm));
    esc_pwm esc_2_i (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                     .frame_start(frame_start), .motor_rate(motor_2_rate), .pwm_out(motor_2_pwm));
    esc_pwm esc_3_i (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                     .frame_start(frame_start), .motor_rate(motor_3_rate), .pwm_out(motor_3_pwm));
    esc_pwm esc_4_i (.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
                     .frame_start(frame_start), .motor_rate(motor_4_rate), .pwm_out(motor_4_pwm));

endmodule

// ==== src/esc_pwm.sv ====
// ESC pulse generator, one pulse per frame with width set by the motor rate
module esc_pwm (
    input  logic                               sys_clk,
    input  logic                               resetn,
    input  logic                               us_tick,
    input  logic                               frame_start,
    input  logic [flight_pkg::stick_width-1:0] motor_rate,
    output logic                               pwm_out
);

    localparam int cw = flight_pkg::width_count_width;

    logic [cw-1:0] pulse_us;
    logic [cw-1:0] remain_us;

    // 1000 us plus 4 us per rate step
    assign pulse_us = cw'(flight_pkg::pulse_min_us)
                    + cw'(motor_rate) * cw'(flight_pkg::us_per_step);

    // Rate sampled only at frame start
    // Output drops when the last microsecond runs out
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            remain_us <= '0;
            pwm_out   <= 1'b0;
        end else if (frame_start) begin
            remain_us <= pulse_us;
            pwm_out   <= 1'b1;
        end else if (us_tick && pwm_out) begin
            if (remain_us == cw'(1)) begin
                pwm_out <= 1'b0;
            end
            remain_us <= remain_us - 1'b1;
        end
    end

endmodule

// ==== src/motor_mixer.sv ====
// Quad-X motor mixer, throttle plus axis rates into four clamped motor rates
module motor_mixer (
    input  logic                                      sys_clk,
    input  logic                                      resetn,
    input  logic                                      ctrl_done,
    input  logic        [flight_pkg::stick_width-1:0] throttle_cmd,
    input  logic signed [flight_pkg::rate_width-1:0]  yaw_rate,
    input  logic signed [flight_pkg::rate_width-1:0]  roll_rate,
    input  logic signed [flight_pkg::rate_width-1:0]  pitch_rate,
    output logic        [flight_pkg::stick_width-1:0] motor_1_rate,
    output logic        [flight_pkg::stick_width-1:0] motor_2_rate,
    output logic        [flight_pkg::stick_width-1:0] motor_3_rate,
    output logic        [flight_pkg::stick_width-1:0] motor_4_rate
);

    // Two guard bits, four terms cannot overflow
    localparam int sum_width = flight_pkg::rate_width + 2;
    localparam int sw = flight_pkg::stick_width;

    logic signed [sum_width-1:0] thr_s;
    logic signed [sum_width-1:0] yaw_s;
    logic signed [sum_width-1:0] roll_s;
    logic signed [sum_width-1:0] pitch_s;
    logic signed [sum_width-1:0] mix_1;
    logic signed [sum_width-1:0] mix_2;
    logic signed [sum_width-1:0] mix_3;
    logic signed [sum_width-1:0] mix_4;

    // Saturate to 0..stick_max
    function automatic logic [sw-1:0] clamp_rate(input logic signed [sum_width-1:0] sum);
        if (sum < 0) begin
            return '0;
        end else if (sum > sum_width'(flight_pkg::stick_max)) begin
            return sw'(flight_pkg::stick_max);
        end
        return sum[sw-1:0];
    endfunction

    // Throttle zero-extends, rates sign-extend
    assign thr_s   = sum_width'(throttle_cmd);
    assign yaw_s   = sum_width'(yaw_rate);
    assign roll_s  = sum_width'(roll_rate);
    assign pitch_s = sum_width'(pitch_rate);

    // Diagonal pairs share yaw direction
    assign mix_1 = thr_s + pitch_s + roll_s - yaw_s;
    assign mix_2 = thr_s + pitch_s - roll_s + yaw_s;
    assign mix_3 = thr_s - pitch_s - roll_s - yaw_s;
    assign mix_4 = thr_s - pitch_s + roll_s + yaw_s;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (ctrl_done) begin
            motor_1_rate <= clamp_rate(mix_1);
            motor_2_rate <= clamp_rate(mix_2);
            motor_3_rate <= clamp_rate(mix_3);
            motor_4_rate <= clamp_rate(mix_4);
        end
    end

endmodule

// ==== src/angle_controller.sv ====
// Angle controller, turns sticks and IMU angles into throttle and per-axis rate commands
module angle_controller (
    input  logic                                      sys_clk,
    input  logic                                      resetn,
    input  logic                                      imu_valid,
    input  logic        [flight_pkg::stick_width-1:0] throttle_stick,
    input  logic        [flight_pkg::stick_width-1:0] yaw_stick,
    input  logic        [flight_pkg::stick_width-1:0] roll_stick,
    input  logic        [flight_pkg::stick_width-1:0] pitch_stick,
    input  logic signed [flight_pkg::angle_width-1:0] roll_angle,
    input  logic signed [flight_pkg::angle_width-1:0] pitch_angle,
    output logic        [flight_pkg::stick_width-1:0] throttle_cmd,
    output logic signed [flight_pkg::rate_width-1:0]  yaw_rate,
    output logic signed [flight_pkg::rate_width-1:0]  roll_rate,
    output logic signed [flight_pkg::rate_width-1:0]  pitch_rate,
    output logic                                      ctrl_done
);

    localparam int sw = flight_pkg::stick_width;
    localparam int rw = flight_pkg::rate_width;
    localparam int aw = flight_pkg::angle_width;

    // One state per axis, idle waits for the IMU strobe
    typedef enum logic [1:0] {
        st_idle,
        st_roll,
        st_pitch,
        st_yaw
    } state_t;

    state_t                state;
    logic        [sw-1:0]  throttle_q;
    logic        [sw-1:0]  yaw_q;
    logic        [sw-1:0]  roll_q;
    logic        [sw-1:0]  pitch_q;
    logic signed [aw-1:0]  roll_angle_q;
    logic signed [aw-1:0]  pitch_angle_q;
    logic        [sw-1:0]  sel_stick;
    logic signed [aw-1:0]  sel_angle;
    logic signed [rw-1:0]  axis_diff;
    logic signed [rw-1:0]  axis_rate;
    logic                  disarmed;

    // Snapshot of sticks and angles, taken only when idle
    always_ff @(posedge sys_clk) begin
        if ((state == st_idle) && imu_valid) begin
            throttle_q    <= throttle_stick;
            yaw_q         <= yaw_stick;
            roll_q        <= roll_stick;
            pitch_q       <= pitch_stick;
            roll_angle_q  <= roll_angle;
            pitch_angle_q <= pitch_angle;
        end
    end

    assign disarmed = throttle_q < sw'(flight_pkg::idle_throttle);

    // Shared subtractor, operands picked by the current axis
    always_comb begin
        sel_stick = roll_q;
        sel_angle = roll_angle_q;
        case (state)
            st_pitch: begin
                sel_stick = pitch_q;
                sel_angle = pitch_angle_q;
            end
            st_yaw: begin
                sel_stick = yaw_q;
                // No yaw angle, stick only
                sel_angle = '0;
            end
            default: begin
            end
        endcase
        axis_diff = rw'(sel_stick) - rw'(flight_pkg::stick_center) - rw'(sel_angle);
        axis_rate = disarmed ? '0 : axis_diff;
    end

    // Roll, pitch, yaw on consecutive cycles, then the done pulse
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state        <= st_idle;
            throttle_cmd <= '0;
            yaw_rate     <= '0;
            roll_rate    <= '0;
            pitch_rate   <= '0;
            ctrl_done    <= 1'b0;
        end else begin
            ctrl_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (imu_valid) begin
                        state <= st_roll;
                    end
                end
                st_roll: begin
                    roll_rate <= axis_rate;
                    state     <= st_pitch;
                end
                st_pitch: begin
                    pitch_rate <= axis_rate;
                    state      <= st_yaw;
                end
                st_yaw: begin
                    yaw_rate     <= axis_rate;
                    throttle_cmd <= throttle_q;
                    ctrl_done    <= 1'b1;
                    state        <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/rc_channel.sv ====
// Receiver channel, measures one pulse width in microseconds and scales it to a stick value
module rc_channel (
    input  logic                               sys_clk,
    input  logic                               resetn,
    input  logic                               us_tick,
    input  logic                               pwm_in,
    output logic [flight_pkg::stick_width-1:0] stick_value
);

    localparam int cw = flight_pkg::width_count_width;

    logic                               sync_0;
    logic                               sync_1;
    logic                               pwm_d;
    logic                               pwm_fall;
    logic [cw-1:0]                      width_cnt;
    logic [cw-1:0]                      excess_us;
    logic [cw-1:0]                      steps;
    logic [flight_pkg::stick_width-1:0] stick_next;

    // Two-flop synchronizer plus one flop of level history
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
            pwm_d  <= 1'b0;
        end else begin
            sync_0 <= pwm_in;
            sync_1 <= sync_0;
            pwm_d  <= sync_1;
        end
    end

    assign pwm_fall = pwm_d && !sync_1;

    // High-time counter, saturates at full range
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            width_cnt <= '0;
        end else if (pwm_fall) begin
            width_cnt <= '0;
        end else if (sync_1 && us_tick && (width_cnt != '1)) begin
            width_cnt <= width_cnt + 1'b1;
        end
    end

    // Strip the zero point, then 4 us per step, truncated
    always_comb begin
        if (width_cnt > cw'(flight_pkg::pulse_min_us)) begin
            excess_us = width_cnt - cw'(flight_pkg::pulse_min_us);
        end else begin
            excess_us = '0;
        end
        steps = excess_us / cw'(flight_pkg::us_per_step);
        // Long pulses pin at full stick
        if (steps > cw'(flight_pkg::stick_max)) begin
            stick_next = flight_pkg::stick_width'(flight_pkg::stick_max);
        end else begin
            stick_next = steps[flight_pkg::stick_width-1:0];
        end
    end

    // Stick value holds until the next falling edge
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            stick_value <= '0;
        end else if (pwm_fall) begin
            stick_value <= stick_next;
        end
    end

endmodule

// ==== src/timebase.sv ====
// Timebase, microsecond tick and ESC frame-start pulse from the system clock
module timebase #(
    parameter int clks_per_us = 1
) (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick,
    output logic frame_start
);

    // Cycle counter needs at least one bit, even at one clock per us
    localparam int cyc_width = $clog2(clks_per_us + 1);

    logic [cyc_width-1:0]                     cyc_cnt;
    logic [flight_pkg::width_count_width-1:0] us_cnt;

    // Tick on the last cycle of each microsecond
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            cyc_cnt <= '0;
            us_tick <= 1'b0;
        end else if (cyc_cnt == cyc_width'(clks_per_us - 1)) begin
            cyc_cnt <= '0;
            us_tick <= 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            us_tick <= 1'b0;
        end
    end

    // Microsecond position inside the frame
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            us_cnt <= '0;
        end else if (us_tick) begin
            if (us_cnt == flight_pkg::width_count_width'(flight_pkg::frame_us - 1)) begin
                us_cnt <= '0;
            end else begin
                us_cnt <= us_cnt + 1'b1;
            end
        end
    end

    // Frame begins on the tick at position zero
    assign frame_start = us_tick && (us_cnt == '0);

endmodule

// ==== src/flight_pkg.sv ====
// Flight-control shared widths, stick scaling constants and ESC frame timing
package flight_pkg;

    // Receiver stick value and motor rate width
    localparam int stick_width = 8;

    // Signed axis rate command
    localparam int rate_width = 16;

    // Signed IMU angle, whole degrees
    localparam int angle_width = 16;

    // Microsecond counters for receiver and ESC pulses
    // 15 bits covers the 20 ms frame
    localparam int width_count_width = 15;

    // Full-scale stick and motor rate
    localparam int stick_max = 250;

    // Neutral stick position
    localparam int stick_center = 125;

    // Pulse width for a zero value, receiver and ESC alike
    localparam int pulse_min_us = 1000;

    // Pulse microseconds per stick step
    // 1000 us span over 250 steps
    localparam int us_per_step = 4;

    // Below this throttle the craft counts as disarmed
    localparam int idle_throttle = 8;

    // ESC frame length, 50 Hz
    localparam int frame_us = 20000;

endpackage
